// ==== include/chk_cfg.svh ====
// Checker configuration macros for widths, stage count and reset pc

`ifndef CHK_CFG_SVH
`define CHK_CFG_SVH

// Virtual address width of the pc
`define CHK_VADDR_W 32

// Toy instruction word
`define CHK_INSTR_W 32

// Architectural register index
`define CHK_REG_W 5

// Calculator stages that report a destination register
`define CHK_STAGES 3

// First pc expected out of reset
`define CHK_RESET_PC 0

`endif

// ==== hdl/chk_pkg.sv ====
// Checker package with the toy opcode encoding, field positions and decode helpers

`include "chk_cfg.svh"

package chk_pkg;

   // Register x0 is hardwired to zero and never causes a hazard

   typedef logic [`CHK_VADDR_W-1:0] vaddr_t;
   typedef logic [`CHK_INSTR_W-1:0] instr_t;
   typedef logic [`CHK_REG_W-1:0]   reg_idx_t;

   // alu and load write rd, store and branch write nothing
   typedef enum logic [1:0] {
      op_alu    = 2'b00,
      op_load   = 2'b01,
      op_store  = 2'b10,
      op_branch = 2'b11
   } opcode_e;

   // Field positions of the toy encoding
   localparam int unsigned op_lsb_lp  = 0;
   localparam int unsigned op_msb_lp  = 1;
   localparam int unsigned rd_lsb_lp  = 7;
   localparam int unsigned rd_msb_lp  = 11;
   localparam int unsigned rs1_lsb_lp = 15;
   localparam int unsigned rs1_msb_lp = 19;
   localparam int unsigned rs2_lsb_lp = 20;
   localparam int unsigned rs2_msb_lp = 24;

   // Fixed instruction size in bytes
   localparam int unsigned instr_bytes_lp = 4;

   function automatic opcode_e decode_op(instr_t instr);
      return opcode_e'(instr[op_msb_lp:op_lsb_lp]);
   endfunction

   function automatic reg_idx_t decode_rd(instr_t instr);
      return instr[rd_msb_lp:rd_lsb_lp];
   endfunction

   function automatic reg_idx_t decode_rs1(instr_t instr);
      return instr[rs1_msb_lp:rs1_lsb_lp];
   endfunction

   function automatic reg_idx_t decode_rs2(instr_t instr);
      return instr[rs2_msb_lp:rs2_lsb_lp];
   endfunction

endpackage

// ==== hdl/chk_scheduler.sv ====
// Checker scheduler that holds one fetched instruction in the issue register and decodes it

module chk_scheduler
  (input  logic              clk_i
   , input  logic            reset_i

   // Fetch queue, yumi in the same cycle as valid
   , input  logic            fe_queue_v_i
   , input  chk_pkg::vaddr_t fe_queue_pc_i
   , input  chk_pkg::instr_t fe_queue_instr_i
   , output logic            fe_queue_yumi_o

   // Release controls from the detector and director
   , input  logic            dispatch_v_i
   , input  logic            poison_i
   , input  logic            flush_i

   // Issue status
   , output logic              isd_v_o
   , output chk_pkg::vaddr_t   isd_pc_o
   , output chk_pkg::instr_t   isd_instr_o
   , output chk_pkg::opcode_e  isd_op_o
   , output chk_pkg::reg_idx_t isd_rs1_o
   , output chk_pkg::reg_idx_t isd_rs2_o
   );

   logic            isd_v_r;
   chk_pkg::vaddr_t isd_pc_r;
   chk_pkg::instr_t isd_instr_r;
   logic            isd_free;

   // Empty or leaving this cycle
   assign isd_free        = ~isd_v_r | dispatch_v_i | poison_i | flush_i;
   assign fe_queue_yumi_o = isd_free & fe_queue_v_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         isd_v_r <= 1'b0;
      end else if (flush_i) begin
         // An entry taken during a flush is wrong-path and is dropped
         isd_v_r <= 1'b0;
      end else if (isd_free) begin
         isd_v_r <= fe_queue_v_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fe_queue_yumi_o) begin
         isd_pc_r    <= fe_queue_pc_i;
         isd_instr_r <= fe_queue_instr_i;
      end
   end

   // Decode straight off the issue register
   assign isd_v_o     = isd_v_r;
   assign isd_pc_o    = isd_pc_r;
   assign isd_instr_o = isd_instr_r;
   assign isd_op_o    = chk_pkg::decode_op(isd_instr_r);
   assign isd_rs1_o   = chk_pkg::decode_rs1(isd_instr_r);
   assign isd_rs2_o   = chk_pkg::decode_rs2(isd_instr_r);

   a_yumi_with_valid : assert property (
      @(posedge clk_i) disable iff (reset_i)
      fe_queue_yumi_o |-> fe_queue_v_i
   );

   // A held instruction keeps its pc and word until it is released
   a_hold_stable : assert property (
      @(posedge clk_i) disable iff (reset_i)
      isd_v_o && !dispatch_v_i && !poison_i && !flush_i
      |=> isd_v_o && $stable(isd_pc_o) && $stable(isd_instr_o)
   );

endmodule

// ==== hdl/chk_director.sv ====
// Checker director that tracks the true next pc and issues redirects on mispredict

`include "chk_cfg.svh"

module chk_director
  (input  logic            clk_i
   , input  logic          reset_i

   // Issue side
   , input  logic            dispatch_v_i
   , input  chk_pkg::vaddr_t isd_pc_i

   // Branch resolution from the calculator
   , input  logic            br_v_i
   , input  chk_pkg::vaddr_t br_pc_i
   , input  chk_pkg::vaddr_t br_tgt_i

   // Status toward the detector
   , output chk_pkg::vaddr_t expected_npc_o
   , output logic            redirect_pending_o
   , output logic            flush_o

   // Redirect command to fetch, valid/ready
   , output logic            fe_cmd_v_o
   , output chk_pkg::vaddr_t fe_cmd_pc_o
   , input  logic            fe_cmd_ready_i
   );

   chk_pkg::vaddr_t expected_npc_r;
   chk_pkg::vaddr_t fe_cmd_pc_r;
   logic            fe_cmd_v_r;
   logic            flush_r;
   logic            br_live;
   logic            mispredict;

   // Branches resolving while a redirect is out are younger and on the wrong path
   assign br_live    = br_v_i & ~fe_cmd_v_r;
   assign mispredict = br_live
                       & (br_tgt_i != br_pc_i + chk_pkg::vaddr_t'(chk_pkg::instr_bytes_lp));

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         expected_npc_r <= chk_pkg::vaddr_t'(`CHK_RESET_PC);
      end else if (br_live) begin
         // Resolved target wins over a same-cycle dispatch
         expected_npc_r <= br_tgt_i;
      end else if (dispatch_v_i) begin
         expected_npc_r <= isd_pc_i + chk_pkg::vaddr_t'(chk_pkg::instr_bytes_lp);
      end
   end

   // One-cycle flush after a mispredict
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         flush_r <= 1'b0;
      end else begin
         flush_r <= mispredict;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         fe_cmd_v_r <= 1'b0;
      end else if (mispredict) begin
         fe_cmd_v_r <= 1'b1;
      end else if (fe_cmd_ready_i) begin
         fe_cmd_v_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (mispredict) begin
         fe_cmd_pc_r <= br_tgt_i;
      end
   end

   assign expected_npc_o     = expected_npc_r;
   assign redirect_pending_o = fe_cmd_v_r;
   assign flush_o            = flush_r;
   assign fe_cmd_v_o         = fe_cmd_v_r;
   assign fe_cmd_pc_o        = fe_cmd_pc_r;

   // Command holds until fetch accepts it
   a_cmd_hold : assert property (
      @(posedge clk_i) disable iff (reset_i)
      fe_cmd_v_o && !fe_cmd_ready_i |=> fe_cmd_v_o && $stable(fe_cmd_pc_o)
   );

   a_flush_single : assert property (
      @(posedge clk_i) disable iff (reset_i)
      flush_o |=> !flush_o
   );

endmodule

// ==== hdl/chk_detector.sv ====
// Checker detector that decides dispatch, hold or poison for the issued instruction

`include "chk_cfg.svh"

module chk_detector
  (input  logic                clk_i
   , input  logic              reset_i

   // Issue status from the scheduler
   , input  logic              isd_v_i
   , input  chk_pkg::vaddr_t   isd_pc_i
   , input  chk_pkg::reg_idx_t isd_rs1_i
   , input  chk_pkg::reg_idx_t isd_rs2_i

   // Control state from the director
   , input  chk_pkg::vaddr_t   expected_npc_i
   , input  logic              redirect_pending_i
   , input  logic              flush_i

   // In-flight destinations, one per calculator stage
   , input  logic [`CHK_STAGES-1:0]              calc_rd_v_i
   , input  chk_pkg::reg_idx_t [`CHK_STAGES-1:0] calc_rd_i

   , output logic              dispatch_v_o
   , output logic              poison_o
   );

   logic [`CHK_STAGES-1:0] rs1_hit;
   logic [`CHK_STAGES-1:0] rs2_hit;
   logic                   data_haz;
   logic                   ctrl_block;
   logic                   pc_match;

   // Per-stage compare, x0 never matches
   always_comb begin
      for (int i = 0; i < `CHK_STAGES; i++) begin
         rs1_hit[i] = calc_rd_v_i[i]
                      && (isd_rs1_i != '0)
                      && (isd_rs1_i == calc_rd_i[i]);
         rs2_hit[i] = calc_rd_v_i[i]
                      && (isd_rs2_i != '0)
                      && (isd_rs2_i == calc_rd_i[i]);
      end
   end

   assign data_haz = |rs1_hit | |rs2_hit;

   // Nothing moves while fetch is being redirected
   assign ctrl_block = flush_i | redirect_pending_i;

   // pc continuity against the architectural next pc
   assign pc_match = (isd_pc_i == expected_npc_i);

   assign dispatch_v_o = isd_v_i & ~ctrl_block & pc_match & ~data_haz;

   // Off-path entries are drained even under a hazard
   assign poison_o = isd_v_i & ~ctrl_block & ~pc_match;

   a_disp_poison_excl : assert property (
      @(posedge clk_i) disable iff (reset_i)
      !(dispatch_v_o && poison_o)
   );

endmodule

// ==== hdl/chk_checker_top.sv ====
// Checker top that joins the scheduler, director and detector between fetch and calculator

`include "chk_cfg.svh"

module chk_checker_top
  (input  logic                                  clk_i
   , input  logic                                reset_i

   // Fetch queue
   , input  logic                                fe_queue_v_i
   , input  chk_pkg::vaddr_t                     fe_queue_pc_i
   , input  chk_pkg::instr_t                     fe_queue_instr_i
   , output logic                                fe_queue_yumi_o

   // Redirect command to fetch
   , output logic                                fe_cmd_v_o
   , output chk_pkg::vaddr_t                     fe_cmd_pc_o
   , input  logic                                fe_cmd_ready_i

   // Calculator status
   , input  logic [`CHK_STAGES-1:0]              calc_rd_v_i
   , input  chk_pkg::reg_idx_t [`CHK_STAGES-1:0] calc_rd_i
   , input  logic                                br_v_i
   , input  chk_pkg::vaddr_t                     br_pc_i
   , input  chk_pkg::vaddr_t                     br_tgt_i

   // Dispatch to the calculator
   , output logic                                dispatch_v_o
   , output chk_pkg::vaddr_t                     dispatch_pc_o
   , output chk_pkg::instr_t                     dispatch_instr_o
   , output logic                                flush_o
   );

   logic              isd_v;
   chk_pkg::vaddr_t   isd_pc;
   chk_pkg::instr_t   isd_instr;
   chk_pkg::reg_idx_t isd_rs1;
   chk_pkg::reg_idx_t isd_rs2;
   chk_pkg::vaddr_t   expected_npc;
   logic              redirect_pending;
   logic              dispatch_v;
   logic              poison;

   chk_scheduler u_scheduler
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.fe_queue_v_i(fe_queue_v_i)
      ,.fe_queue_pc_i(fe_queue_pc_i)
      ,.fe_queue_instr_i(fe_queue_instr_i)
      ,.fe_queue_yumi_o(fe_queue_yumi_o)
      ,.dispatch_v_i(dispatch_v)
      ,.poison_i(poison)
      ,.flush_i(flush_o)
      ,.isd_v_o(isd_v)
      ,.isd_pc_o(isd_pc)
      ,.isd_instr_o(isd_instr)
      ,.isd_op_o()
      ,.isd_rs1_o(isd_rs1)
      ,.isd_rs2_o(isd_rs2)
      );

   chk_director u_director
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.dispatch_v_i(dispatch_v)
      ,.isd_pc_i(isd_pc)
      ,.br_v_i(br_v_i)
      ,.br_pc_i(br_pc_i)
      ,.br_tgt_i(br_tgt_i)
      ,.expected_npc_o(expected_npc)
      ,.redirect_pending_o(redirect_pending)
      ,.flush_o(flush_o)
      ,.fe_cmd_v_o(fe_cmd_v_o)
      ,.fe_cmd_pc_o(fe_cmd_pc_o)
      ,.fe_cmd_ready_i(fe_cmd_ready_i)
      );

   chk_detector u_detector
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.isd_v_i(isd_v)
      ,.isd_pc_i(isd_pc)
      ,.isd_rs1_i(isd_rs1)
      ,.isd_rs2_i(isd_rs2)
      ,.expected_npc_i(expected_npc)
      ,.redirect_pending_i(redirect_pending)
      ,.flush_i(flush_o)
      ,.calc_rd_v_i(calc_rd_v_i)
      ,.calc_rd_i(calc_rd_i)
      ,.dispatch_v_o(dispatch_v)
      ,.poison_o(poison)
      );

   // Dispatch payload comes straight from the issue register
   assign dispatch_v_o     = dispatch_v;
   assign dispatch_pc_o    = isd_pc;
   assign dispatch_instr_o = isd_instr;

endmodule

// ==== bench/chk_tb.sv ====
// Checker testbench driving seeded random fetch and calculator traffic against a reference model

`include "chk_cfg.svh"

module chk_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam chk_pkg::vaddr_t pc_step = 4;

   logic                                clk_i;
   logic                                reset_i;
   logic                                fe_queue_v_i;
   chk_pkg::vaddr_t                     fe_queue_pc_i;
   chk_pkg::instr_t                     fe_queue_instr_i;
   logic                                fe_queue_yumi_o;
   logic                                fe_cmd_v_o;
   chk_pkg::vaddr_t                     fe_cmd_pc_o;
   logic                                fe_cmd_ready_i;
   logic [`CHK_STAGES-1:0]              calc_rd_v_i;
   chk_pkg::reg_idx_t [`CHK_STAGES-1:0] calc_rd_i;
   logic                                br_v_i;
   chk_pkg::vaddr_t                     br_pc_i;
   chk_pkg::vaddr_t                     br_tgt_i;
   logic                                dispatch_v_o;
   chk_pkg::vaddr_t                     dispatch_pc_o;
   chk_pkg::instr_t                     dispatch_instr_o;
   logic                                flush_o;

   integer seed = 90921;
   int     n_chk;
   int     n_err;

   // Reference model of issue register, next pc and redirect
   logic            m_isd_v, m_cmd_v, m_flush;
   chk_pkg::vaddr_t m_isd_pc, m_npc, m_cmd_pc;
   chk_pkg::instr_t m_isd_instr;

   // Fetch stream and branch bookkeeping
   chk_pkg::vaddr_t fe_seq_pc, fe_cur_pc, br_pend_pc, watch_pc, prev_pc;
   chk_pkg::instr_t fe_cur_instr;
   int              fe_wrong_left;
   logic            br_pend, watch_v, prev_v;

   // Events seen in the running test
   int c_disp, c_haz, c_flush, c_good, c_poison;

   chk_checker_top u_chk_checker_top (.*);

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   function automatic int unsigned rand_below(int unsigned range);
      int r;
      r = $random(seed);
      return $unsigned(r) % range;
   endfunction

   function automatic chk_pkg::vaddr_t rand_aligned_pc();
      logic [31:0] r;
      r = $random(seed);
      return chk_pkg::vaddr_t'({r[31:2], 2'b00});
   endfunction

   // Random word with register fields from a small pool so hazards are common
   function automatic chk_pkg::instr_t make_instr();
      chk_pkg::instr_t w;
      w = chk_pkg::instr_t'($random(seed));
      w[chk_pkg::rd_msb_lp:chk_pkg::rd_lsb_lp]   = chk_pkg::reg_idx_t'(rand_below(8));
      w[chk_pkg::rs1_msb_lp:chk_pkg::rs1_lsb_lp] = chk_pkg::reg_idx_t'(rand_below(8));
      w[chk_pkg::rs2_msb_lp:chk_pkg::rs2_lsb_lp] = chk_pkg::reg_idx_t'(rand_below(8));
      return w;
   endfunction

   // Stale entries come first after a redirect
   function automatic void next_fetch_entry();
      if (fe_wrong_left > 0) begin
         fe_cur_pc = rand_aligned_pc();
         fe_wrong_left--;
      end else begin
         fe_cur_pc = fe_seq_pc;
         fe_seq_pc = fe_seq_pc + pc_step;
      end
      fe_cur_instr = make_instr();
   endfunction

   task automatic check_bit(string name, logic act, logic exp);
      n_chk++;
      if (act !== exp) begin
         n_err++;
         $display("[FAIL] t=%0t %s got %b expected %b", $time, name, act, exp);
      end
   endtask

   task automatic check_pc(string name, chk_pkg::vaddr_t act, chk_pkg::vaddr_t exp);
      n_chk++;
      if (act !== exp) begin
         n_err++;
         $display("[FAIL] t=%0t %s got %h expected %h", $time, name, act, exp);
      end
   endtask

   task automatic check_instr(string name, chk_pkg::instr_t act, chk_pkg::instr_t exp);
      n_chk++;
      if (act !== exp) begin
         n_err++;
         $display("[FAIL] t=%0t %s got %h expected %h", $time, name, act, exp);
      end
   endtask

   // One clock: drive on the falling edge, check before the rising edge, advance the model
   task automatic step(bit haz_en, bit br_en);
      chk_pkg::reg_idx_t rs1, rs2;
      logic haz, blk, match, exp_disp, exp_poison, free, exp_yumi, mispredict, cmd_xfer;
      rs1 = m_isd_instr[chk_pkg::rs1_msb_lp:chk_pkg::rs1_lsb_lp];
      rs2 = m_isd_instr[chk_pkg::rs2_msb_lp:chk_pkg::rs2_lsb_lp];
      @(negedge clk_i);
      fe_queue_v_i     = (rand_below(4) != 0);
      fe_queue_pc_i    = fe_cur_pc;
      fe_queue_instr_i = fe_cur_instr;
      fe_cmd_ready_i   = br_en ? (rand_below(3) == 0) : 1'b1;
      haz = 1'b0;
      for (int i = 0; i < `CHK_STAGES; i++) begin
         calc_rd_v_i[i] = haz_en && (rand_below(2) != 0);
         calc_rd_i[i]   = chk_pkg::reg_idx_t'(rand_below(8));
         if (i == 0 && haz_en && rand_below(4) == 0) calc_rd_i[i] = rs1;
         if (calc_rd_v_i[i] && ((rs1 != '0 && rs1 == calc_rd_i[i])
                                || (rs2 != '0 && rs2 == calc_rd_i[i])))
            haz = 1'b1;
      end
      blk        = m_flush | m_cmd_v;
      match      = (m_isd_pc == m_npc);
      exp_disp   = m_isd_v & ~blk & match & ~haz;
      exp_poison = m_isd_v & ~blk & ~match;
      free       = ~m_isd_v | exp_disp | exp_poison | m_flush;
      exp_yumi   = free & fe_queue_v_i;
      // Branch report never overlaps a younger dispatch
      br_v_i   = br_en && br_pend && !exp_disp && !m_cmd_v;
      br_pc_i  = br_pend_pc;
      br_tgt_i = (rand_below(2) != 0) ? br_pend_pc + pc_step : rand_aligned_pc();
      #1;
      check_bit("fe_queue_yumi_o", fe_queue_yumi_o, exp_yumi);
      check_bit("dispatch_v_o", dispatch_v_o, exp_disp);
      check_bit("flush_o", flush_o, m_flush);
      check_bit("fe_cmd_v_o", fe_cmd_v_o, m_cmd_v);
      if (m_cmd_v) check_pc("fe_cmd_pc_o", fe_cmd_pc_o, m_cmd_pc);
      if (exp_disp) begin
         check_pc("dispatch_pc_o", dispatch_pc_o, m_isd_pc);
         check_instr("dispatch_instr_o", dispatch_instr_o, m_isd_instr);
         // No branches means a strictly sequential stream
         if (!br_en && prev_v) check_pc("dispatch_pc_o", dispatch_pc_o, prev_pc + pc_step);
         if (watch_v) check_pc("dispatch_pc_o", dispatch_pc_o, watch_pc);
         watch_v    = 1'b0;
         prev_v     = 1'b1;
         prev_pc    = m_isd_pc;
         br_pend    = (chk_pkg::opcode_e'(m_isd_instr[chk_pkg::op_msb_lp:chk_pkg::op_lsb_lp])
                       == chk_pkg::op_branch);
         br_pend_pc = m_isd_pc;
         c_disp++;
      end
      if (m_isd_v && !blk && match && haz) c_haz++;
      if (exp_poison) c_poison++;
      if (m_flush) c_flush++;
      mispredict = br_v_i && (br_tgt_i != br_pc_i + pc_step);
      if (br_v_i && !mispredict) c_good++;
      if (br_v_i) br_pend = 1'b0;
      cmd_xfer = m_cmd_v & fe_cmd_ready_i;
      if (br_v_i) m_npc = br_tgt_i;
      else if (exp_disp) m_npc = m_isd_pc + pc_step;
      if (m_flush) m_isd_v = 1'b0;
      else if (free) m_isd_v = fe_queue_v_i;
      if (exp_yumi) begin
         m_isd_pc    = fe_queue_pc_i;
         m_isd_instr = fe_queue_instr_i;
      end
      if (mispredict) begin
         m_cmd_v  = 1'b1;
         m_cmd_pc = br_tgt_i;
         watch_v  = 1'b1;
         watch_pc = br_tgt_i;
      end else if (fe_cmd_ready_i) begin
         m_cmd_v = 1'b0;
      end
      m_flush = mispredict;
      if (cmd_xfer) begin
         fe_wrong_left = int'(rand_below(3));
         fe_seq_pc     = m_cmd_pc;
         next_fetch_entry();
      end else if (exp_yumi) begin
         next_fetch_entry();
      end
   endtask

   task automatic run_test(string name, bit haz_en, bit br_en, int disp_goal, int haz_goal,
                           int flush_goal, int good_goal, int poison_goal);
      int  cyc;
      int  err0;
      bit  done;
      err0     = n_err;
      cyc      = 0;
      done     = 1'b0;
      c_disp   = 0;
      c_haz    = 0;
      c_flush  = 0;
      c_good   = 0;
      c_poison = 0;
      while (!done && cyc < 4000) begin
         step(haz_en, br_en);
         cyc++;
         done = c_disp >= disp_goal && c_haz >= haz_goal && c_flush >= flush_goal
                && c_good >= good_goal && c_poison >= poison_goal;
      end
      if (!done) begin
         n_err++;
         $display("%s timed out after %0d cycles before reaching its event counts", name, cyc);
      end
      $display("test %-10s cycles=%0d disp=%0d hold=%0d flush=%0d good_br=%0d poison=%0d err=%0d",
               name, cyc, c_disp, c_haz, c_flush, c_good, c_poison, n_err - err0);
   endtask

   initial begin
      reset_i          = 1'b1;
      fe_queue_v_i     = 1'b0;
      fe_queue_pc_i    = '0;
      fe_queue_instr_i = '0;
      fe_cmd_ready_i   = 1'b0;
      calc_rd_v_i      = '0;
      calc_rd_i        = '0;
      br_v_i           = 1'b0;
      br_pc_i          = '0;
      br_tgt_i         = '0;
      n_chk            = 0;
      n_err            = 0;
      m_isd_v          = 1'b0;
      m_isd_pc         = '0;
      m_isd_instr      = '0;
      m_npc            = chk_pkg::vaddr_t'(`CHK_RESET_PC);
      m_cmd_v          = 1'b0;
      m_cmd_pc         = '0;
      m_flush          = 1'b0;
      br_pend          = 1'b0;
      watch_v          = 1'b0;
      prev_v           = 1'b0;
      fe_wrong_left    = 0;
      fe_seq_pc        = chk_pkg::vaddr_t'(`CHK_RESET_PC);
      next_fetch_entry();
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      #1;
      check_bit("dispatch_v_o", dispatch_v_o, 1'b0);
      check_bit("fe_queue_yumi_o", fe_queue_yumi_o, 1'b0);
      check_bit("fe_cmd_v_o", fe_cmd_v_o, 1'b0);
      check_bit("flush_o", flush_o, 1'b0);
      $display("test reset      err=%0d", n_err);
      run_test("in_order", 1'b0, 1'b0, 40, 0, 0, 0, 0);
      run_test("hazard", 1'b1, 1'b0, 40, 5, 0, 0, 0);
      run_test("mispredict", 1'b1, 1'b1, 0, 0, 4, 2, 0);
      run_test("wrong_path", 1'b1, 1'b1, 10, 0, 2, 0, 8);
      $display("checks=%0d errors=%0d", n_chk, n_err);
      if (n_err == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+include
hdl/chk_pkg.sv
hdl/chk_scheduler.sv
hdl/chk_director.sv
hdl/chk_detector.sv
hdl/chk_checker_top.sv
bench/chk_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the checker testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   -f build.f \
   --top-module chk_tb \
   -o chk_sim

./obj_dir/chk_sim | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
   exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
